// ==== list.f ====
lmfe_pkg.sv
line_buffer.sv
row_loader.sv
window_scanner.sv
median_rank49.sv
lmfe_top.sv
tb_clock.sv
lmfe_tb.sv

// ==== Makefile ====
TOP = lmfe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: compile
	out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== lmfe_tb.sv ====
`timescale 1ns/1ps

module lmfe_tb;
    import lmfe_pkg::*;

    localparam int     NPIX         = IMG_W * IMG_H;
    localparam longint FRAME_CYCLES = longint'(NPIX) * 9 + longint'(IMG_H) * 60;
    localparam longint WD_NS        = 4 * FRAME_CYCLES * 20;

    logic   clk;
    logic   reset;
    logic   in_en;
    pixel_t Din;
    logic   busy;
    logic   out_valid;
    pixel_t Dout;

    integer seed;
    pixel_t img [IMG_H][IMG_W];            // image of the frame in flight
    pixel_t got_q [$];                     // medians in arrival order

    tb_clock i_clk (
        .clk (clk)
    );

    lmfe_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_en     (in_en),
        .Din       (Din),
        .busy      (busy),
        .out_valid (out_valid),
        .Dout      (Dout)
    );

    // outputs are registered, sampled away from the rising edge
    always @(negedge clk) begin
        if (out_valid) begin
            got_q.push_back(Dout);
        end
    end

    initial begin : watchdog
        #(WD_NS);
        $display("timeout: outputs stopped arriving after %0d ns", WD_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // sorted zero-padded 7x7 window, middle entry
    function automatic int ref_median(input int r, input int c);
        int vals [WIN*WIN];
        int n;
        int v;
        int j;
        int y;
        int x;
        n = 0;
        for (int dy = -HALF; dy <= HALF; dy++) begin
            for (int dx = -HALF; dx <= HALF; dx++) begin
                y = r + dy;
                x = c + dx;
                v = (y >= 0 && y < IMG_H && x >= 0 && x < IMG_W) ? int'(img[y][x]) : 0;
                j = n;
                while (j > 0 && vals[j-1] > v) begin
                    vals[j] = vals[j-1];
                    j--;
                end
                vals[j] = v;
                n++;
            end
        end
        return vals[MEDIAN_IDX];
    endfunction

    task automatic fill_image(input bit random_fill, input int value);
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                img[y][x] = random_fill ? pixel_t'($random(seed)) : pixel_t'(value);
            end
        end
    endtask

    // busy can only rise after the last pixel of a row, so pause there one cycle
    task automatic feed_frame(input bit gaps);
        int   idx;
        logic busy_s;
        logic row_edge;
        logic offer;
        idx = 0;
        while (idx < NPIX) begin
            @(negedge clk);
            busy_s = busy;                 // holds until the next rising edge
            @(posedge clk);
            row_edge = 1'b0;
            if (in_en) begin
                check_val("busy", 0, busy_s);
                idx++;
                row_edge = (idx % IMG_W == 0);
            end
            offer = (idx < NPIX) && !busy_s && !row_edge;
            if (offer && gaps && ($random(seed) % 2 != 0)) begin
                offer = 1'b0;              // random idle cycle
            end
            in_en <= offer;
            if (offer) begin
                Din <= img[idx / IMG_W][idx % IMG_W];
            end
        end
    endtask

    task automatic run_frame(input bit gaps);
        got_q.delete();
        feed_frame(gaps);
        while (got_q.size() < NPIX) begin
            @(posedge clk);
        end
        repeat (2 * WIN * WIN) @(posedge clk);   // no extra medians may follow
        check_val("out_valid count", NPIX, got_q.size());
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                check_val($sformatf("Dout[%0d][%0d]", r, c), ref_median(r, c),
                          got_q[r * IMG_W + c]);
            end
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("busy", 0, busy);
        check_val("out_valid", 0, out_valid);
    endtask

    task automatic test_constant_frame();
        fill_image(1'b0, 100);
        run_frame(1'b0);
        check_val("Dout[64][64]", 100, got_q[64 * IMG_W + 64]);
        check_val("Dout[0][0]", 0, got_q[0]);   // 16 of 49 inside the image
        check_val("Dout[127][127]", 0, got_q[NPIX - 1]);
    endtask

    task automatic test_random_frame();
        fill_image(1'b1, 0);
        run_frame(1'b0);
    endtask

    task automatic test_gapped_input();
        fill_image(1'b1, 0);
        run_frame(1'b1);
    endtask

    task automatic test_back_to_back();
        fill_image(1'b1, 0);
        run_frame(1'b0);
    endtask

    initial begin
        seed  = 32'hb91b;
        reset = 1'b1;
        in_en = 1'b0;
        Din   = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_constant_frame();
        test_random_frame();
        test_gapped_input();
        test_back_to_back();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;            // 20 ns period
    end

endmodule

// ==== lmfe_top.sv ====
`timescale 1ns/1ps

module lmfe_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_en,
    input  lmfe_pkg::pixel_t Din,
    output logic             busy,
    output logic             out_valid,
    output lmfe_pkg::pixel_t Dout
);
    import lmfe_pkg::*;

    lb_write_t  wr;
    row_cnt_t   rows_loaded;
    logic       row_done;
    slot_t      new_slot;
    slot_t      old_slot;
    col_t       new_col;
    col_t       old_col;
    pixel_t     new_pix;
    pixel_t     old_pix;
    median_op_t op;
    logic       op_valid;

    row_loader i_loader (
        .clk         (clk),
        .reset       (reset),
        .in_en       (in_en),
        .Din         (Din),
        .row_done    (row_done),
        .busy        (busy),
        .wr          (wr),
        .rows_loaded (rows_loaded)
    );

    line_buffer i_lbuf (
        .clk      (clk),
        .wr       (wr),
        .new_slot (new_slot),
        .old_slot (old_slot),
        .new_col  (new_col),
        .old_col  (old_col),
        .new_pix  (new_pix),
        .old_pix  (old_pix)
    );

    window_scanner i_scan (
        .clk         (clk),
        .reset       (reset),
        .rows_loaded (rows_loaded),
        .new_slot    (new_slot),
        .old_slot    (old_slot),
        .new_col     (new_col),
        .old_col     (old_col),
        .new_pix     (new_pix),
        .old_pix     (old_pix),
        .op          (op),
        .op_valid    (op_valid),
        .row_done    (row_done)
    );

    median_rank49 i_rank (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .op_valid  (op_valid),
        .Dout      (Dout),
        .out_valid (out_valid)
    );

endmodule

// ==== median_rank49.sv ====
`timescale 1ns/1ps

module median_rank49 (
    input  logic                 clk,
    input  logic                 reset,
    input  lmfe_pkg::median_op_t op,
    input  logic                 op_valid,
    output lmfe_pkg::pixel_t     Dout,
    output logic                 out_valid
);
    import lmfe_pkg::*;

    pixel_t                 arr     [WIN*WIN];  // ascending, first fill_cnt valid
    pixel_t                 del_arr [WIN*WIN];
    pixel_t                 nxt_arr [WIN*WIN];
    logic [5:0]             fill_cnt;
    logic [5:0]             cnt_base;
    logic [5:0]             cnt_del;
    logic [5:0]             nxt_cnt;
    logic [WIN*WIN-1:0]     less;
    logic                   del_on;
    logic                   ins_on;
    logic                   seen;
    logic                   last_d;

    assign del_on = op_valid && op.del_valid;
    assign ins_on = op_valid && op.ins_valid;

    always_comb begin
        cnt_base = op.clear ? '0 : fill_cnt;

        // drop the first copy of del and close the gap
        seen = 1'b0;
        for (int i = 0; i < WIN*WIN - 1; i++) begin
            if (!seen && del_on && (i < cnt_base) && (arr[i] == op.del)) begin
                seen = 1'b1;
            end
            del_arr[i] = seen ? arr[i+1] : arr[i];
        end
        if (!seen && del_on && (cnt_base == 6'(WIN*WIN)) && (arr[WIN*WIN-1] == op.del)) begin
            seen = 1'b1;
        end
        del_arr[WIN*WIN-1] = arr[WIN*WIN-1];
        cnt_del = cnt_base - {5'b0, seen};

        // entries below ins form a prefix
        for (int i = 0; i < WIN*WIN; i++) begin
            less[i] = (i < cnt_del) && (del_arr[i] < op.ins);
        end

        nxt_arr[0] = (!ins_on || less[0]) ? del_arr[0] : op.ins;
        for (int i = 1; i < WIN*WIN; i++) begin
            if (!ins_on || less[i]) begin
                nxt_arr[i] = del_arr[i];
            end else if (less[i-1]) begin
                nxt_arr[i] = op.ins;       // insert point
            end else begin
                nxt_arr[i] = del_arr[i-1];
            end
        end
        nxt_cnt = cnt_del + {5'b0, ins_on};
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            arr <= nxt_arr;
        end
        if (last_d) begin
            Dout <= arr[MEDIAN_IDX];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_cnt  <= '0;
            last_d    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (op_valid) begin
                fill_cnt <= nxt_cnt;
            end
            last_d    <= op_valid && op.last;
            out_valid <= last_d;           // one cycle per median
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (reset)
        fill_cnt <= 6'(WIN*WIN));

    // a delete that misses means the scanner re-read a different value
    a_del_found: assert property (@(posedge clk) disable iff (reset)
        (op_valid && op.del_valid && !op.clear) |-> seen);

endmodule

// ==== window_scanner.sv ====
`timescale 1ns/1ps

module window_scanner (
    input  logic                 clk,
    input  logic                 reset,
    input  lmfe_pkg::row_cnt_t   rows_loaded,
    output lmfe_pkg::slot_t      new_slot,
    output lmfe_pkg::slot_t      old_slot,
    output lmfe_pkg::col_t       new_col,
    output lmfe_pkg::col_t       old_col,
    input  lmfe_pkg::pixel_t     new_pix,
    input  lmfe_pkg::pixel_t     old_pix,
    output lmfe_pkg::median_op_t op,
    output logic                 op_valid,
    output logic                 row_done
);
    import lmfe_pkg::*;

    scan_state_t state;
    col_t        out_row;
    col_t        out_col;
    slot_t       wrow;                     // window row 0..6
    slot_t       fill_col;                 // window column 0..6 during fill
    slot_t       c_slot;                   // slot of the center row
    row_cnt_t    need;
    logic [4:0]  slot_sum;
    slot_t       win_slot;
    int          win_row;
    int          new_x;
    int          old_x;
    logic        row_pad;
    logic        new_pad;
    logic        old_pad;
    logic        issue;
    logic        last;

    // one stage, lines up with the line buffer read latency
    logic        p_valid;
    logic        p_clear;
    logic        p_last;
    logic        p_ins_pad;
    logic        p_del_valid;
    logic        p_del_pad;

    assign need = (out_row > col_t'(IMG_H - HALF - 1)) ? row_cnt_t'(IMG_H)
                : row_cnt_t'(out_row) + row_cnt_t'(HALF + 1);

    assign win_row = int'(out_row) + int'(wrow) - HALF;
    assign new_x   = (state == fill) ? int'(fill_col) - HALF : int'(out_col) + HALF;
    assign old_x   = int'(out_col) - HALF - 1;

    assign row_pad = (win_row < 0) || (win_row > IMG_H - 1);
    assign new_pad = row_pad || (new_x < 0) || (new_x > IMG_W - 1);
    assign old_pad = row_pad || (old_x < 0) || (old_x > IMG_W - 1);

    // c_slot + wrow - 3 taken mod 7
    assign slot_sum = {2'b00, c_slot} + {2'b00, wrow} + 5'(ROW_SLOTS - HALF);
    assign win_slot = (slot_sum >= 5'(2 * ROW_SLOTS)) ? slot_t'(slot_sum - 5'(2 * ROW_SLOTS))
                    : (slot_sum >= 5'(ROW_SLOTS))     ? slot_t'(slot_sum - 5'(ROW_SLOTS))
                    : slot_t'(slot_sum);

    // rows outside the image park on the center row, always loaded
    assign new_slot = row_pad ? c_slot : win_slot;
    assign old_slot = new_slot;
    assign new_col  = new_pad ? '0 : col_t'(new_x);
    assign old_col  = (state == slide) ? (old_pad ? '0 : col_t'(old_x))
                    : (state == fill)  ? new_col
                    : ~new_col;            // idle, mirror column

    assign issue    = (state == fill) || (state == slide);
    assign last     = (wrow == slot_t'(WIN - 1)) && (state == slide || fill_col == slot_t'(WIN - 1));
    assign row_done = (state == row_end);

    assign op = '{clear:     p_clear,
                  ins_valid: 1'b1,
                  ins:       p_ins_pad ? '0 : new_pix,
                  del_valid: p_del_valid,
                  del:       p_del_pad ? '0 : old_pix,
                  last:      p_last};
    assign op_valid = p_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p_valid     <= 1'b0;
            p_clear     <= 1'b0;
            p_last      <= 1'b0;
            p_ins_pad   <= 1'b0;
            p_del_valid <= 1'b0;
            p_del_pad   <= 1'b0;
        end else begin
            p_valid     <= issue;
            p_clear     <= (state == fill) && (wrow == '0) && (fill_col == '0);
            p_last      <= issue && last;
            p_ins_pad   <= new_pad;
            p_del_valid <= (state == slide);
            p_del_pad   <= old_pad;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= wait_rows;
            out_row  <= '0;
            out_col  <= '0;
            wrow     <= '0;
            fill_col <= '0;
            c_slot   <= '0;
        end else begin
            case (state)
                wait_rows: begin
                    if (rows_loaded >= need) begin
                        state <= fill;
                    end
                end
                fill: begin
                    wrow <= (wrow == slot_t'(WIN - 1)) ? '0 : wrow + 1'b1;
                    if (wrow == slot_t'(WIN - 1)) begin
                        if (fill_col == slot_t'(WIN - 1)) begin
                            fill_col <= '0;
                            out_col  <= col_t'(1);  // first window done, pixel 0
                            state    <= slide;
                        end else begin
                            fill_col <= fill_col + 1'b1;
                        end
                    end
                end
                slide: begin
                    wrow <= (wrow == slot_t'(WIN - 1)) ? '0 : wrow + 1'b1;
                    if (wrow == slot_t'(WIN - 1)) begin
                        if (out_col == col_t'(IMG_W - 1)) begin
                            state <= row_end;
                        end else begin
                            out_col <= out_col + 1'b1;
                        end
                    end
                end
                row_end: begin
                    out_col <= '0;
                    state   <= wait_rows;
                    if (out_row == col_t'(IMG_H - 1)) begin
                        out_row <= '0;     // next frame
                        c_slot  <= '0;
                    end else begin
                        out_row <= out_row + 1'b1;
                        c_slot  <= (c_slot == slot_t'(ROW_SLOTS - 1)) ? '0 : c_slot + 1'b1;
                    end
                end
                default: state <= wait_rows;
            endcase
        end
    end

    a_no_op_waiting: assert property (@(posedge clk) disable iff (reset)
        $rose(op_valid) |-> state != wait_rows);

endmodule

// ==== row_loader.sv ====
`timescale 1ns/1ps

module row_loader (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_en,
    input  lmfe_pkg::pixel_t    Din,
    input  logic                row_done,
    output logic                busy,
    output lmfe_pkg::lb_write_t wr,
    output lmfe_pkg::row_cnt_t  rows_loaded
);
    import lmfe_pkg::*;

    col_t     wr_col;
    slot_t    wr_slot;
    row_cnt_t rows_done;                   // output rows finished by the scanner
    logic     row_ok;
    logic     accept;
    logic     frame_end;

    // row L may overwrite row L-7 once output row L-4 is finished
    assign row_ok = (rows_loaded < row_cnt_t'(ROW_SLOTS))
                 || (rows_loaded <= rows_done + row_cnt_t'(HALF));
    assign busy   = !row_ok || (rows_loaded == row_cnt_t'(IMG_H));
    assign accept = in_en && !busy;

    assign frame_end = row_done && (rows_done == row_cnt_t'(IMG_H - 1));

    assign wr = '{valid: accept, slot: wr_slot, col: wr_col, pix: Din};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_col      <= '0;
            wr_slot     <= '0;
            rows_loaded <= '0;
            rows_done   <= '0;
        end else begin
            if (accept) begin
                wr_col <= wr_col + 1'b1;   // wraps after the last column
                if (wr_col == col_t'(IMG_W - 1)) begin
                    rows_loaded <= rows_loaded + 1'b1;
                    wr_slot     <= (wr_slot == slot_t'(ROW_SLOTS - 1)) ? '0 : wr_slot + 1'b1;
                end
            end
            if (frame_end) begin
                // no accept here, busy holds while all rows are loaded
                rows_loaded <= '0;
                rows_done   <= '0;
                wr_slot     <= '0;
            end else if (row_done) begin
                rows_done <= rows_done + 1'b1;
            end
        end
    end

    a_slot_bound: assert property (@(posedge clk) disable iff (reset)
        rows_loaded <= rows_done + row_cnt_t'(ROW_SLOTS));

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
    input  logic                clk,
    input  lmfe_pkg::lb_write_t wr,
    input  lmfe_pkg::slot_t     new_slot,
    input  lmfe_pkg::slot_t     old_slot,
    input  lmfe_pkg::col_t      new_col,
    input  lmfe_pkg::col_t      old_col,
    output lmfe_pkg::pixel_t    new_pix,
    output lmfe_pkg::pixel_t    old_pix
);
    import lmfe_pkg::*;

    pixel_t mem [ROW_SLOTS][IMG_W];        // slot = image row mod 7

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.slot][wr.col] <= wr.pix;
        end
        new_pix <= mem[new_slot][new_col]; // insert side of the window
        old_pix <= mem[old_slot][old_col]; // delete side
    end

    // loader overwrote a row the scanner still holds in its window
    a_no_rw_clash: assert property (@(posedge clk)
        !(wr.valid && wr.slot == new_slot && wr.col == new_col
          && wr.slot == old_slot && wr.col == old_col));

endmodule

// ==== lmfe_pkg.sv ====
package lmfe_pkg;

    localparam int IMG_W      = 128;
    localparam int IMG_H      = 128;
    localparam int WIN        = 7;
    localparam int HALF       = 3;         // window radius
    localparam int MEDIAN_IDX = 24;        // middle of 49 sorted entries
    localparam int ROW_SLOTS  = 7;         // rows held in the line buffer

    typedef logic [7:0] pixel_t;
    typedef logic [6:0] col_t;
    typedef logic [7:0] row_cnt_t;         // 0 to 128
    typedef logic [2:0] slot_t;

    // one pixel write into the line buffer
    typedef struct packed {
        logic   valid;
        slot_t  slot;
        col_t   col;
        pixel_t pix;
    } lb_write_t;

    // one rank update, delete and insert in the same cycle
    typedef struct packed {
        logic   clear;                     // empty the array before this op
        logic   ins_valid;
        pixel_t ins;
        logic   del_valid;
        pixel_t del;
        logic   last;                      // final op of an output pixel
    } median_op_t;

    typedef enum logic [1:0] {
        wait_rows,
        fill,
        slide,
        row_end
    } scan_state_t;

endpackage
